// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := apb_periph_tb
FILELIST  := apb_periph.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: apb_periph.f
hw/apb_pkg.sv
hw/apb_interconnect.sv
hw/apb_reg_slave.sv
hw/apb_periph_top.sv
verif/apb_periph_tb.sv

// File: hw/apb_interconnect.sv
/* Address decoder between one requester and n_slv peripherals; forwards each
   access to the first matching window and returns the registered answer */

`default_nettype none

module apb_interconnect #(
    parameter logic [apb_pkg::n_slv-1:0][apb_pkg::addr_w-1:0] slv_base =
        {16'd32, 16'd16, 16'd0},
    parameter logic [apb_pkg::n_slv-1:0][apb_pkg::addr_w-1:0] slv_size =
        {16'd16, 16'd16, 16'd16}
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    input  apb_pkg::apb_req_t s_req,
    output apb_pkg::apb_rsp_t s_rsp,
    output apb_pkg::apb_req_t m_req [apb_pkg::n_slv],
    input  apb_pkg::apb_rsp_t m_rsp [apb_pkg::n_slv]
);

    localparam int sel_w = (apb_pkg::n_slv > 1) ? $clog2(apb_pkg::n_slv) : 1;

    logic [apb_pkg::n_slv-1:0] hit;
    logic [apb_pkg::n_slv-1:0] m_en;
    logic [sel_w-1:0]          sel;
    logic                      any_hit;

    // Window compare one bit wider so base+size cannot wrap
    for (genvar i = 0; i < apb_pkg::n_slv; i++) begin : gen_win
        assign hit[i] = ({1'b0, s_req.addr} >= {1'b0, slv_base[i]}) &&
                        ({1'b0, s_req.addr} < ({1'b0, slv_base[i]} + {1'b0, slv_size[i]}));
        assign m_en[i] = m_req[i].en;
    end

    assign any_hit = |hit;

    // Scan downwards so the lowest index wins on overlap
    always_comb begin
        sel = '0;
        for (int i = apb_pkg::n_slv - 1; i >= 0; i--) begin
            if (hit[i]) begin
                sel = i[sel_w-1:0];
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < apb_pkg::n_slv; i++) begin
                m_req[i] <= '0;
            end
            s_rsp <= '0;
        end else if (srst) begin
            for (int i = 0; i < apb_pkg::n_slv; i++) begin
                m_req[i] <= '0;
            end
            s_rsp <= '0;
        end else if (s_req.en && !s_rsp.ready) begin
            if (any_hit) begin
                m_req[sel].en    <= 1'b1;
                m_req[sel].wr    <= s_req.wr;
                m_req[sel].addr  <= s_req.addr - slv_base[sel];
                m_req[sel].wdata <= s_req.wdata;
                m_req[sel].strb  <= s_req.strb;
                s_rsp.rdata      <= m_rsp[sel].rdata;
                s_rsp.ready      <= m_rsp[sel].ready;
                // Peripheral answered, release it
                if (m_rsp[sel].ready) begin
                    m_req[sel].en <= 1'b0;
                end
            end else begin
                // Unmapped access completes by itself
                s_rsp.rdata <= '0;
                s_rsp.ready <= 1'b1;
            end
        end else begin
            // Idle between accesses
            for (int i = 0; i < apb_pkg::n_slv; i++) begin
                m_req[i] <= '0;
            end
            s_rsp <= '0;
        end
    end

    // Only one peripheral may be addressed at a time
    one_target : assert property (
        @(posedge aclk) disable iff (!aresetn || srst)
        $onehot0(m_en)
    );

    // Requester holds the access until it is answered
    req_stable : assert property (
        @(posedge aclk) disable iff (!aresetn || srst)
        (s_req.en && !s_rsp.ready) |=>
            (s_req.en && $stable({s_req.wr, s_req.addr, s_req.wdata, s_req.strb}))
    );

endmodule

`default_nettype wire

// File: hw/apb_periph_top.sv
/* Peripheral subsystem: one address-decoding interconnect feeding n_slv
   identical register file peripherals */

`default_nettype none

module apb_periph_top #(
    parameter logic [apb_pkg::n_slv-1:0][apb_pkg::addr_w-1:0] slv_base =
        {16'd32, 16'd16, 16'd0},
    parameter logic [apb_pkg::n_slv-1:0][apb_pkg::addr_w-1:0] slv_size =
        {16'd16, 16'd16, 16'd16},
    parameter int depth       = 4,
    parameter int wait_states = 2
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    input  apb_pkg::apb_req_t s_req,
    output apb_pkg::apb_rsp_t s_rsp
);

    apb_pkg::apb_req_t m_req [apb_pkg::n_slv];
    apb_pkg::apb_rsp_t m_rsp [apb_pkg::n_slv];

    apb_interconnect #(
        .slv_base (slv_base),
        .slv_size (slv_size)
    ) u_interconnect (
        .aclk    (aclk),
        .aresetn (aresetn),
        .srst    (srst),
        .s_req   (s_req),
        .s_rsp   (s_rsp),
        .m_req   (m_req),
        .m_rsp   (m_rsp)
    );

    // One register file per window
    for (genvar i = 0; i < apb_pkg::n_slv; i++) begin : gen_slv
        apb_reg_slave #(
            .depth       (depth),
            .wait_states (wait_states)
        ) u_slv (
            .aclk    (aclk),
            .aresetn (aresetn),
            .srst    (srst),
            .req     (m_req[i]),
            .rsp     (m_rsp[i])
        );
    end

endmodule

`default_nettype wire

// File: hw/apb_pkg.sv
/* Bus widths, peripheral count and the request/response structs shared by
   the interconnect, the register peripherals and the testbench */

`default_nettype none

package apb_pkg;

    localparam int addr_w = 16;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // Peripherals behind the interconnect
    localparam int n_slv = 3;

    // One access from requester to responder, held until ready
    typedef struct packed {
        logic              en;
        logic              wr;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] strb;
    } apb_req_t;

    // Answer, ready pulses for one cycle
    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              ready;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: hw/apb_reg_slave.sv
/* Scratch register file peripheral; answers each access after a fixed
   number of wait states and supports byte-strobed writes */

`default_nettype none

module apb_reg_slave #(
    parameter int depth       = 4,
    parameter int wait_states = 2
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp
);

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

    logic [apb_pkg::data_w-1:0] mem [depth];
    logic [cnt_w-1:0]           cnt;
    logic [idx_w-1:0]           idx;
    logic                       fire;

    // Word index from byte address, wrapped onto the file
    assign idx = idx_w'((req.addr >> 2) % depth);

    // Last wait cycle of an access not yet answered
    assign fire = req.en && !rsp.ready && (cnt == cnt_w'(wait_states));

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cnt <= '0;
            rsp <= '0;
        end else if (srst) begin
            cnt <= '0;
            rsp <= '0;
        end else begin
            rsp.ready <= 1'b0;
            rsp.rdata <= '0;
            if (fire) begin
                cnt       <= '0;
                rsp.ready <= 1'b1;
                if (!req.wr) begin
                    rsp.rdata <= mem[idx];
                end
            end else if (req.en && !rsp.ready) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
        end
    end

    // Storage, emptied by the synchronous clear
    always_ff @(posedge aclk) begin
        if (srst) begin
            for (int w = 0; w < depth; w++) begin
                mem[w] <= '0;
            end
        end else if (fire && req.wr) begin
            for (int b = 0; b < apb_pkg::strb_w; b++) begin
                if (req.strb[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // An answer follows a request held through every wait state
    ready_has_req : assert property (
        @(posedge aclk) disable iff (!aresetn)
        rsp.ready |-> ($past(req.en) && $past(req.en, wait_states + 1))
    );

endmodule

`default_nettype wire

// File: verif/apb_periph_tb.sv
/* Directed testbench for the peripheral subsystem; checks every read against
   a memory model of the three register files and prints the counts */

`default_nettype none

module apb_periph_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_win   = apb_pkg::n_slv;
    localparam int n_word  = 4;
    localparam int win_sz  = 16;
    localparam int timeout = 100;

    logic              aclk;
    logic              aresetn;
    logic              srst;
    apb_pkg::apb_req_t s_req;
    apb_pkg::apb_rsp_t s_rsp;

    // Expected contents, indexed by window and word
    logic [31:0] model [n_win][n_word];
    logic [31:0] rng_state;
    int          pass_count;
    int          fail_count;

    apb_periph_top dut (
        .aclk    (aclk),
        .aresetn (aresetn),
        .srst    (srst),
        .s_req   (s_req),
        .s_rsp   (s_rsp)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #10 aclk = ~aclk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Byte lanes with strobe set take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [15:0] word_addr(input int win, input int word);
        return 16'(win * win_sz + word * 4);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_count++;
            $display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
        end else begin
            pass_count++;
        end
    endtask

    task automatic test_done(input string name, input int first_fail);
        $display("test %s finished with %0d errors", name, fail_count - first_fail);
    endtask

    task automatic bus_access(input logic wr, input logic [15:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        rdata  = '0;
        @(negedge aclk);
        s_req.en    = 1'b1;
        s_req.wr    = wr;
        s_req.addr  = addr;
        s_req.wdata = wdata;
        s_req.strb  = strb;
        while (s_rsp.ready !== 1'b1 && cycles < timeout) begin
            @(negedge aclk);
            cycles++;
        end
        if (s_rsp.ready !== 1'b1) begin
            fail_count++;
            $display("Timeout: access to address %04h got no ready within %0d cycles",
                     addr, timeout);
            $display("Something failed");
            $finish;
        end else begin
            rdata = s_rsp.rdata;
            // Hold the access through the cycle after ready
            @(negedge aclk);
            s_req = '0;
            if (s_rsp.ready !== 1'b0) begin
                fail_count++;
                $display("Ready for address %04h stayed high for more than one cycle",
                         addr);
            end
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, strb, unused);
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, '0, '0, data);
    endtask

    // Fills every word of every window, so later tests see known contents
    task automatic test_write_read();
        int          first;
        logic [31:0] rd;
        first = fail_count;
        for (int w = 0; w < n_win; w++) begin
            for (int k = 0; k < n_word; k++) begin
                rng_state = xorshift32(rng_state);
                bus_write(word_addr(w, k), rng_state, 4'hf);
                model[w][k] = rng_state;
                bus_read(word_addr(w, k), rd);
                check_value("write_read", model[w][k], rd);
            end
        end
        test_done("write_read", first);
    endtask

    task automatic test_partial_strobe();
        int          first;
        logic [3:0]  strobes [4];
        logic [31:0] rd;
        first = fail_count;
        strobes = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        for (int w = 0; w < n_win; w++) begin
            for (int s = 0; s < 4; s++) begin
                rng_state = xorshift32(rng_state);
                bus_write(word_addr(w, w), rng_state, strobes[s]);
                model[w][w] = merge_bytes(model[w][w], rng_state, strobes[s]);
                bus_read(word_addr(w, w), rd);
                check_value("partial_strobe", model[w][w], rd);
            end
        end
        test_done("partial_strobe", first);
    endtask

    task automatic test_window_split();
        int          first;
        logic [31:0] values [3];
        logic [31:0] rd;
        first = fail_count;
        values = '{32'h0123_4567, 32'h89ab_cdef, 32'h5a5a_c3c3};
        for (int w = 0; w < n_win; w++) begin
            bus_write(word_addr(w, 2), values[w], 4'hf);
            model[w][2] = values[w];
        end
        for (int w = 0; w < n_win; w++) begin
            bus_read(word_addr(w, 2), rd);
            check_value("window_split", model[w][2], rd);
        end
        test_done("window_split", first);
    endtask

    task automatic test_unmapped();
        int          first;
        logic [31:0] rd;
        first = fail_count;
        bus_write(16'd48, 32'hdead_beef, 4'hf);
        bus_write(16'h8000, 32'hcafe_f00d, 4'hf);
        bus_read(16'd48, rd);
        check_value("unmapped", 32'h0, rd);
        bus_read(16'hfffc, rd);
        check_value("unmapped", 32'h0, rd);
        // Mapped windows must be untouched
        for (int w = 0; w < n_win; w++) begin
            for (int k = 0; k < n_word; k++) begin
                bus_read(word_addr(w, k), rd);
                check_value("unmapped", model[w][k], rd);
            end
        end
        test_done("unmapped", first);
    endtask

    task automatic test_clear();
        int          first;
        logic [31:0] rd;
        first = fail_count;
        @(negedge aclk);
        srst = 1'b1;
        repeat (2) @(negedge aclk);
        srst = 1'b0;
        for (int w = 0; w < n_win; w++) begin
            for (int k = 0; k < n_word; k++) begin
                model[w][k] = '0;
                bus_read(word_addr(w, k), rd);
                check_value("clear", model[w][k], rd);
            end
        end
        test_done("clear", first);
    endtask

    task automatic test_random();
        int          first;
        int          win;
        int          word;
        logic [3:0]  strb;
        logic [31:0] rd;
        first = fail_count;
        for (int n = 0; n < 40; n++) begin
            rng_state = xorshift32(rng_state);
            win  = int'(rng_state % 3);
            word = int'((rng_state >> 8) % 4);
            strb = rng_state[19:16];
            rng_state = xorshift32(rng_state);
            bus_write(word_addr(win, word), rng_state, strb);
            model[win][word] = merge_bytes(model[win][word], rng_state, strb);
            bus_read(word_addr(win, word), rd);
            check_value("random", model[win][word], rd);
        end
        test_done("random", first);
    endtask

    initial begin
        s_req      = '0;
        srst       = 1'b0;
        aresetn    = 1'b0;
        rng_state  = 32'd85;
        pass_count = 0;
        fail_count = 0;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        test_write_read();
        test_partial_strobe();
        test_window_split();
        test_unmapped();
        test_clear();
        test_random();

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
